// File: Makefile
SRCS := $(wildcard logic/*.sv logic/*.svh test/*.sv test/*.svh) sim.f

.PHONY: run clean

run: obj_dir/Vtb_id_stage
	obj_dir/Vtb_id_stage

obj_dir/Vtb_id_stage: $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module tb_id_stage

clean:
	rm -rf obj_dir

// File: logic/branch_resolver.sv
// resolves beq/bne/j/jal, gives taken flag, target and link address
`default_nettype none

`include "cpu_consts.svh"

module branch_resolver (
    input  cpu_pkg::pc_t   i_pc,
    input  cpu_pkg::inst_t i_inst,
    input  cpu_pkg::word_t i_op_a,
    input  cpu_pkg::word_t i_op_b,
    input  logic           i_is_branch_eq,
    input  logic           i_is_branch_ne,
    input  logic           i_is_jump,
    output logic           o_branch_vld,
    output cpu_pkg::pc_t   o_branch_addr,
    output cpu_pkg::pc_t   o_link_addr
);

    import cpu_pkg::*;

    pc_t  pc_plus_4;
    pc_t  pc_plus_8;
    pc_t  br_offset;
    pc_t  jump_target;
    logic cond_taken;

    assign pc_plus_4 = i_pc + `N_INST_ADDR'd4;
    assign pc_plus_8 = i_pc + `N_INST_ADDR'd8;

    // offset in words, sign extended
    assign br_offset   = {{(`N_INST_ADDR-18){i_inst[15]}}, i_inst[15:0], 2'b00};
    assign jump_target = {pc_plus_4[`N_INST_ADDR-1:28], i_inst[25:0], 2'b00};

    assign cond_taken = (i_is_branch_eq && (i_op_a == i_op_b))
                     || (i_is_branch_ne && (i_op_a != i_op_b));

    always_comb begin
        o_branch_vld  = 1'b0;
        o_branch_addr = '0;
        o_link_addr   = '0;
        if (i_is_jump) begin
            o_branch_vld  = 1'b1;
            o_branch_addr = jump_target;
            o_link_addr   = pc_plus_8;  // return past the delay slot
        end else if (cond_taken) begin
            o_branch_vld  = 1'b1;
            o_branch_addr = pc_plus_4 + br_offset;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_consts.svh
// widths, opcode/function codes and issue credits, included by every decode stage file
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define N_REG           32  // data word
`define N_INST          32
`define N_INST_ADDR     32  // pc
`define N_REG_ADDR      5

// primary opcode field, inst[31:26]
`define OPC_SPECIAL     6'b000000
`define OPC_J           6'b000010
`define OPC_JAL         6'b000011
`define OPC_BEQ         6'b000100
`define OPC_BNE         6'b000101
`define OPC_ADDIU       6'b001001
`define OPC_ANDI        6'b001100
`define OPC_ORI         6'b001101
`define OPC_XORI        6'b001110
`define OPC_LUI         6'b001111

// function field of special ops, inst[5:0]
`define FN_ADDU         6'b100001
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111

`define LINK_REG        5'd31  // jal destination

// execute stage issue slots
`define N_CREDIT        2
`define ID_CREDITS      2'd2

`endif

// File: logic/cpu_pkg.sv
// shared word, address and instruction types plus alu operation enums for the decode stage
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`N_REG-1:0]       word_t;
    typedef logic [`N_INST_ADDR-1:0] pc_t;
    typedef logic [`N_REG_ADDR-1:0]  reg_idx_t;
    typedef logic [`N_INST-1:0]      inst_t;

    // result class seen by execute
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_ARITH = 3'b100,
        SEL_JUMP  = 3'b110
    } alu_sel_t;

    typedef enum logic [7:0] {
        OP_NOP  = 8'b0000_0000,
        OP_OR   = 8'b0010_0101,
        OP_AND  = 8'b0010_0100,
        OP_XOR  = 8'b0010_0110,
        OP_NOR  = 8'b0010_0111,
        OP_ADDU = 8'b0010_0001,
        OP_SUBU = 8'b0010_0011,
        OP_JAL  = 8'b0101_0000
    } alu_op_t;

endpackage

`default_nettype wire

// File: logic/id_stage.sv
// decode stage top, reads and forwards operands, resolves branches, issues to ex under credits
`default_nettype none

`include "cpu_consts.svh"

module id_stage (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_inst_vld,
    input  cpu_pkg::inst_t    i_inst,
    input  cpu_pkg::pc_t      i_pc,
    output logic              o_inst_rdy,
    input  logic              i_ex_wen,
    input  cpu_pkg::reg_idx_t i_ex_waddr,
    input  cpu_pkg::word_t    i_ex_wdata,
    input  logic              i_mem_wen,
    input  cpu_pkg::reg_idx_t i_mem_waddr,
    input  cpu_pkg::word_t    i_mem_wdata,
    input  logic              i_wb_wen,
    input  cpu_pkg::reg_idx_t i_wb_waddr,
    input  cpu_pkg::word_t    i_wb_wdata,
    input  logic              i_credit,
    output logic              o_ex_vld,
    output cpu_pkg::alu_op_t  o_alu_op,
    output cpu_pkg::alu_sel_t o_alu_sel,
    output cpu_pkg::word_t    o_op_a,
    output cpu_pkg::word_t    o_op_b,
    output logic              o_reg_wen,
    output cpu_pkg::reg_idx_t o_reg_waddr,
    output logic              o_branch_vld,
    output cpu_pkg::pc_t      o_branch_addr,
    output cpu_pkg::pc_t      o_link_addr
);

    import cpu_pkg::*;

    logic [`N_CREDIT-1:0] credit_cnt;
    logic                 accept;

    alu_op_t  dec_alu_op;
    alu_sel_t dec_alu_sel;
    logic     ren_a;
    logic     ren_b;
    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rf_data_a;
    word_t    rf_data_b;
    logic     dec_reg_wen;
    reg_idx_t dec_reg_waddr;
    word_t    imm;
    logic     is_branch_eq;
    logic     is_branch_ne;
    logic     is_jump;
    word_t    op_a;
    word_t    op_b;
    logic     br_vld;
    pc_t      br_addr;
    pc_t      link_addr;

    assign o_inst_rdy = (credit_cnt != '0);
    assign accept     = i_inst_vld && o_inst_rdy;

    regfile u_regfile (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wen     (i_wb_wen),
        .i_waddr   (i_wb_waddr),
        .i_wdata   (i_wb_wdata),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rf_data_a),
        .o_rdata_b (rf_data_b)
    );

    inst_decoder u_inst_decoder (
        .i_inst         (i_inst),
        .o_alu_op       (dec_alu_op),
        .o_alu_sel      (dec_alu_sel),
        .o_ren_a        (ren_a),
        .o_ren_b        (ren_b),
        .o_raddr_a      (raddr_a),
        .o_raddr_b      (raddr_b),
        .o_reg_wen      (dec_reg_wen),
        .o_reg_waddr    (dec_reg_waddr),
        .o_imm          (imm),
        .o_is_branch_eq (is_branch_eq),
        .o_is_branch_ne (is_branch_ne),
        .o_is_jump      (is_jump)
    );

    operand_bypass u_bypass_a (
        .i_ren       (ren_a),
        .i_raddr     (raddr_a),
        .i_rf_data   (rf_data_a),
        .i_imm       (imm),
        .i_ex_wen    (i_ex_wen),
        .i_ex_waddr  (i_ex_waddr),
        .i_ex_wdata  (i_ex_wdata),
        .i_mem_wen   (i_mem_wen),
        .i_mem_waddr (i_mem_waddr),
        .i_mem_wdata (i_mem_wdata),
        .o_operand   (op_a)
    );

    operand_bypass u_bypass_b (
        .i_ren       (ren_b),
        .i_raddr     (raddr_b),
        .i_rf_data   (rf_data_b),
        .i_imm       (imm),
        .i_ex_wen    (i_ex_wen),
        .i_ex_waddr  (i_ex_waddr),
        .i_ex_wdata  (i_ex_wdata),
        .i_mem_wen   (i_mem_wen),
        .i_mem_waddr (i_mem_waddr),
        .i_mem_wdata (i_mem_wdata),
        .o_operand   (op_b)
    );

    branch_resolver u_branch_resolver (
        .i_pc           (i_pc),
        .i_inst         (i_inst),
        .i_op_a         (op_a),
        .i_op_b         (op_b),
        .i_is_branch_eq (is_branch_eq),
        .i_is_branch_ne (is_branch_ne),
        .i_is_jump      (is_jump),
        .o_branch_vld   (br_vld),
        .o_branch_addr  (br_addr),
        .o_link_addr    (link_addr)
    );

    // accept and return in one cycle cancel out
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            credit_cnt <= `ID_CREDITS;
        end else if (accept && !i_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (i_credit && !accept && (credit_cnt != `ID_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_vld     <= 1'b0;
            o_reg_wen    <= 1'b0;
            o_branch_vld <= 1'b0;
        end else begin
            o_ex_vld <= accept;  // one cycle per issue
            if (accept) begin
                o_reg_wen    <= dec_reg_wen;
                o_branch_vld <= br_vld;
            end
        end
    end

    // payload, qualified by o_ex_vld
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_alu_op      <= dec_alu_op;
            o_alu_sel     <= dec_alu_sel;
            o_op_a        <= op_a;
            o_op_b        <= op_b;
            o_reg_waddr   <= dec_reg_waddr;
            o_branch_addr <= br_addr;
            o_link_addr   <= link_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
// instruction decoder, maps opcode/function to alu op, register reads, destination and immediate
`default_nettype none

`include "cpu_consts.svh"

module inst_decoder (
    input  cpu_pkg::inst_t    i_inst,
    output cpu_pkg::alu_op_t  o_alu_op,
    output cpu_pkg::alu_sel_t o_alu_sel,
    output logic              o_ren_a,
    output logic              o_ren_b,
    output cpu_pkg::reg_idx_t o_raddr_a,
    output cpu_pkg::reg_idx_t o_raddr_b,
    output logic              o_reg_wen,
    output cpu_pkg::reg_idx_t o_reg_waddr,
    output cpu_pkg::word_t    o_imm,
    output logic              o_is_branch_eq,
    output logic              o_is_branch_ne,
    output logic              o_is_jump
);

    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_zext;
    word_t      imm_sext;
    word_t      imm_upper;

    assign opcode = i_inst[31:26];
    assign funct  = i_inst[5:0];
    assign rs     = i_inst[25:21];
    assign rt     = i_inst[20:16];
    assign rd     = i_inst[15:11];

    assign imm_zext  = {{(`N_REG-16){1'b0}}, i_inst[15:0]};
    assign imm_sext  = {{(`N_REG-16){i_inst[15]}}, i_inst[15:0]};
    assign imm_upper = {i_inst[15:0], {(`N_REG-16){1'b0}}};  // lui

    always_comb begin
        o_alu_op       = OP_NOP;
        o_alu_sel      = SEL_NOP;
        o_ren_a        = 1'b0;
        o_ren_b        = 1'b0;
        o_raddr_a      = rs;
        o_raddr_b      = rt;
        o_reg_wen      = 1'b0;
        o_reg_waddr    = '0;
        o_imm          = '0;
        o_is_branch_eq = 1'b0;
        o_is_branch_ne = 1'b0;
        o_is_jump      = 1'b0;

        case (opcode)
            `OPC_SPECIAL: begin
                o_alu_sel = SEL_LOGIC;
                case (funct)
                    `FN_OR:   o_alu_op = OP_OR;
                    `FN_AND:  o_alu_op = OP_AND;
                    `FN_XOR:  o_alu_op = OP_XOR;
                    `FN_NOR:  o_alu_op = OP_NOR;
                    `FN_ADDU: begin
                        o_alu_op  = OP_ADDU;
                        o_alu_sel = SEL_ARITH;
                    end
                    `FN_SUBU: begin
                        o_alu_op  = OP_SUBU;
                        o_alu_sel = SEL_ARITH;
                    end
                    default:  o_alu_sel = SEL_NOP;  // unknown funct, plain nop
                endcase
                if (o_alu_sel != SEL_NOP) begin
                    o_ren_a     = 1'b1;
                    o_ren_b     = 1'b1;
                    o_reg_wen   = 1'b1;
                    o_reg_waddr = rd;
                end
            end
            `OPC_ORI, `OPC_ANDI, `OPC_XORI, `OPC_LUI, `OPC_ADDIU: begin
                o_ren_a     = 1'b1;  // port b carries the immediate
                o_reg_wen   = 1'b1;
                o_reg_waddr = rt;
                o_alu_sel   = SEL_LOGIC;
                o_imm       = imm_zext;
                case (opcode)
                    `OPC_ANDI:  o_alu_op = OP_AND;
                    `OPC_XORI:  o_alu_op = OP_XOR;
                    `OPC_LUI: begin
                        o_alu_op  = OP_OR;
                        o_raddr_a = '0;  // r0 | upper imm
                        o_imm     = imm_upper;
                    end
                    `OPC_ADDIU: begin
                        o_alu_op  = OP_ADDU;
                        o_alu_sel = SEL_ARITH;
                        o_imm     = imm_sext;
                    end
                    default:    o_alu_op = OP_OR;
                endcase
            end
            `OPC_BEQ, `OPC_BNE: begin
                o_ren_a        = 1'b1;
                o_ren_b        = 1'b1;
                o_is_branch_eq = (opcode == `OPC_BEQ);
                o_is_branch_ne = (opcode == `OPC_BNE);
            end
            `OPC_J: o_is_jump = 1'b1;
            `OPC_JAL: begin
                o_is_jump   = 1'b1;
                o_alu_op    = OP_JAL;
                o_alu_sel   = SEL_JUMP;
                o_reg_wen   = 1'b1;
                o_reg_waddr = `LINK_REG;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/operand_bypass.sv
// source operand select with ex/mem forwarding, one instance per read port
`default_nettype none

`include "cpu_consts.svh"

module operand_bypass (
    input  logic              i_ren,
    input  cpu_pkg::reg_idx_t i_raddr,
    input  cpu_pkg::word_t    i_rf_data,
    input  cpu_pkg::word_t    i_imm,
    input  logic              i_ex_wen,
    input  cpu_pkg::reg_idx_t i_ex_waddr,
    input  cpu_pkg::word_t    i_ex_wdata,
    input  logic              i_mem_wen,
    input  cpu_pkg::reg_idx_t i_mem_waddr,
    input  cpu_pkg::word_t    i_mem_wdata,
    output cpu_pkg::word_t    o_operand
);

    logic ex_hit;
    logic mem_hit;

    // r0 is never forwarded
    assign ex_hit  = i_ex_wen  && (i_ex_waddr  == i_raddr) && (i_raddr != '0);
    assign mem_hit = i_mem_wen && (i_mem_waddr == i_raddr) && (i_raddr != '0);

    always_comb begin
        if (!i_ren) begin
            o_operand = i_imm;
        end else if (ex_hit) begin  // newest result wins
            o_operand = i_ex_wdata;
        end else if (mem_hit) begin
            o_operand = i_mem_wdata;
        end else begin
            o_operand = i_rf_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/regfile.sv
// general purpose register file, two async read ports and one write port, r0 reads zero
`default_nettype none

`include "cpu_consts.svh"

module regfile (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_wen,
    input  logic [`N_REG_ADDR-1:0]  i_waddr,
    input  logic [`N_REG-1:0]       i_wdata,
    input  logic [`N_REG_ADDR-1:0]  i_raddr_a,
    input  logic [`N_REG_ADDR-1:0]  i_raddr_b,
    output logic [`N_REG-1:0]       o_rdata_a,
    output logic [`N_REG-1:0]       o_rdata_b
);

    localparam int N_ENTRY = 2 ** `N_REG_ADDR;

    logic [`N_REG-1:0] regs [N_ENTRY];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < N_ENTRY; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_waddr != '0)) begin  // r0 stays zero
            regs[i_waddr] <= i_wdata;
        end
    end

    // no write-through, new value seen next cycle
    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
+incdir+test
logic/cpu_pkg.sv
logic/regfile.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/branch_resolver.sv
logic/id_stage.sv
test/tb_id_stage.sv

// File: test/tb_id_model.svh
// reference model for decode, operand select and branch resolve, plus the register mirror
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

typedef struct packed {
    alu_op_t  op;
    alu_sel_t sel;
    word_t    op_a;
    word_t    op_b;
    logic     wen;
    reg_idx_t waddr;
    logic     br_vld;
    pc_t      br_addr;
    pc_t      link;
} bundle_t;

word_t mirror [32];  // follows every writeback

// newest forwarded result wins, r0 never forwards
function automatic word_t pick_operand(logic ren, reg_idx_t addr, word_t imm);
    if (!ren) return imm;
    if (i_ex_wen && i_ex_waddr == addr && addr != 0) return i_ex_wdata;
    if (i_mem_wen && i_mem_waddr == addr && addr != 0) return i_mem_wdata;
    return mirror[addr];
endfunction

function automatic bundle_t expect_issue(inst_t inst, pc_t pc);
    bundle_t    b;
    logic [5:0] opc;
    reg_idx_t   ra;
    logic       ren_a;
    logic       ren_b;
    word_t      imm;
    pc_t        pc4;
    opc   = inst[31:26];
    ra    = inst[25:21];
    ren_a = 1'b0;
    ren_b = 1'b0;
    imm   = '0;
    pc4   = pc + 32'd4;
    b     = '0;
    b.op  = OP_NOP;
    b.sel = SEL_NOP;
    case (opc)
        `OPC_SPECIAL: begin
            case (inst[5:0])
                `FN_OR:   begin b.op = OP_OR;   b.sel = SEL_LOGIC; end
                `FN_AND:  begin b.op = OP_AND;  b.sel = SEL_LOGIC; end
                `FN_XOR:  begin b.op = OP_XOR;  b.sel = SEL_LOGIC; end
                `FN_NOR:  begin b.op = OP_NOR;  b.sel = SEL_LOGIC; end
                `FN_ADDU: begin b.op = OP_ADDU; b.sel = SEL_ARITH; end
                `FN_SUBU: begin b.op = OP_SUBU; b.sel = SEL_ARITH; end
                default:  b.sel = SEL_NOP;
            endcase
            if (b.sel != SEL_NOP) begin
                ren_a   = 1'b1;
                ren_b   = 1'b1;
                b.wen   = 1'b1;
                b.waddr = inst[15:11];
            end
        end
        `OPC_ORI, `OPC_ANDI, `OPC_XORI, `OPC_LUI, `OPC_ADDIU: begin
            ren_a   = 1'b1;
            b.wen   = 1'b1;
            b.waddr = inst[20:16];
            b.sel   = SEL_LOGIC;
            imm     = {16'h0, inst[15:0]};
            if (opc == `OPC_ORI) b.op = OP_OR;
            if (opc == `OPC_ANDI) b.op = OP_AND;
            if (opc == `OPC_XORI) b.op = OP_XOR;
            if (opc == `OPC_LUI) begin
                b.op = OP_OR;
                ra   = '0;  // lui reads r0
                imm  = {inst[15:0], 16'h0};
            end
            if (opc == `OPC_ADDIU) begin
                b.op  = OP_ADDU;
                b.sel = SEL_ARITH;
                imm   = {{16{inst[15]}}, inst[15:0]};
            end
        end
        `OPC_BEQ, `OPC_BNE: begin
            ren_a = 1'b1;
            ren_b = 1'b1;
        end
        `OPC_JAL: begin
            b.op    = OP_JAL;
            b.sel   = SEL_JUMP;
            b.wen   = 1'b1;
            b.waddr = `LINK_REG;
        end
        default: begin
        end
    endcase
    b.op_a = pick_operand(ren_a, ra, imm);
    b.op_b = pick_operand(ren_b, inst[20:16], imm);
    if (opc == `OPC_J || opc == `OPC_JAL) begin
        b.br_vld  = 1'b1;
        b.br_addr = {pc4[31:28], inst[25:0], 2'b00};
        b.link    = pc + 32'd8;
    end else if ((opc == `OPC_BEQ && b.op_a == b.op_b)
              || (opc == `OPC_BNE && b.op_a != b.op_b)) begin
        b.br_vld  = 1'b1;
        b.br_addr = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    end
    return b;
endfunction

`endif

// File: test/tb_id_stage.sv
// testbench for the decode stage, random ops, forwarding, branches and credit flow
`default_nettype none

`include "cpu_consts.svh"

module tb_id_stage;

    import cpu_pkg::*;

    localparam int N_PLAN = 51;  // planned instructions

    logic     i_clk;
    logic     i_arst_n;
    logic     i_inst_vld;
    inst_t    i_inst;
    pc_t      i_pc;
    logic     i_ex_wen;
    reg_idx_t i_ex_waddr;
    word_t    i_ex_wdata;
    logic     i_mem_wen;
    reg_idx_t i_mem_waddr;
    word_t    i_mem_wdata;
    logic     i_wb_wen;
    reg_idx_t i_wb_waddr;
    word_t    i_wb_wdata;
    logic     i_credit;
    logic     o_inst_rdy;
    logic     o_ex_vld;
    alu_op_t  o_alu_op;
    alu_sel_t o_alu_sel;
    word_t    o_op_a;
    word_t    o_op_b;
    logic     o_reg_wen;
    reg_idx_t o_reg_waddr;
    logic     o_branch_vld;
    pc_t      o_branch_addr;
    pc_t      o_link_addr;

    int    cyc;
    int    n_issued;
    int    owed;  // issued, credit not yet returned
    logic  auto_credit;
    logic  force_credit;
    string cur_test;
    int    n0;

    logic [5:0] fns [6] = '{`FN_OR, `FN_AND, `FN_XOR, `FN_NOR, `FN_ADDU, `FN_SUBU};
    logic [5:0] opcs [5] = '{`OPC_ORI, `OPC_ANDI, `OPC_XORI, `OPC_LUI, `OPC_ADDIU};

    `include "tb_id_model.svh"

    bundle_t exp_q [$];
    int      due_q [$];

    id_stage DUT (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_inst_vld(i_inst_vld), .i_inst(i_inst),
        .i_pc(i_pc), .o_inst_rdy(o_inst_rdy), .i_ex_wen(i_ex_wen), .i_ex_waddr(i_ex_waddr),
        .i_ex_wdata(i_ex_wdata), .i_mem_wen(i_mem_wen), .i_mem_waddr(i_mem_waddr),
        .i_mem_wdata(i_mem_wdata), .i_wb_wen(i_wb_wen), .i_wb_waddr(i_wb_waddr),
        .i_wb_wdata(i_wb_wdata), .i_credit(i_credit), .o_ex_vld(o_ex_vld),
        .o_alu_op(o_alu_op), .o_alu_sel(o_alu_sel), .o_op_a(o_op_a), .o_op_b(o_op_b),
        .o_reg_wen(o_reg_wen), .o_reg_waddr(o_reg_waddr), .o_branch_vld(o_branch_vld),
        .o_branch_addr(o_branch_addr), .o_link_addr(o_link_addr)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    initial cyc = 0;
    always @(posedge i_clk) cyc <= cyc + 1;

    task automatic stop_failed(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_field(string field, logic [31:0] exp, logic [31:0] act);
        string line;
        line = $sformatf("** Error %s %s: expected %h, actual %h", cur_test, field, exp, act);
        assert (exp === act) else stop_failed(line);
    endtask

    function automatic inst_t r_type(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {`OPC_SPECIAL, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic inst_t i_type(logic [5:0] opc, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic pc_t rnd_pc();
        return {30'($urandom), 2'b00};
    endfunction

    // issue checker, outputs stable at the falling edge
    always @(negedge i_clk) begin
        bundle_t e;
        int      due;
        if (o_ex_vld) begin
            assert (exp_q.size() > 0) else stop_failed("issue seen with nothing accepted");
            e   = exp_q.pop_front();
            due = due_q.pop_front();
            compare_field("issue cycle", 32'(due), 32'(cyc));
            compare_field("alu_op", 32'(e.op), 32'(o_alu_op));
            compare_field("alu_sel", 32'(e.sel), 32'(o_alu_sel));
            compare_field("op_a", e.op_a, o_op_a);
            compare_field("op_b", e.op_b, o_op_b);
            compare_field("reg_wen", 32'(e.wen), 32'(o_reg_wen));
            compare_field("reg_waddr", 32'(e.waddr), 32'(o_reg_waddr));
            compare_field("branch_vld", 32'(e.br_vld), 32'(o_branch_vld));
            compare_field("branch_addr", e.br_addr, o_branch_addr);
            compare_field("link_addr", e.link, o_link_addr);
            n_issued++;
            owed++;
        end
    end

    // credit return, random gaps
    always @(posedge i_clk) begin
        #1;
        if (force_credit) begin
            i_credit     = 1'b1;
            force_credit = 1'b0;
            owed--;
        end else if (auto_credit && owed > 0 && $urandom_range(2) == 0) begin
            i_credit = 1'b1;
            owed--;
        end else begin
            i_credit = 1'b0;
        end
    end

    initial begin
        #((N_PLAN * 20 + 200) * 4);
        stop_failed("watchdog expired before the tests finished");
    end

    // all tasks below start and end 1 unit after a rising edge
    task automatic wb_write(reg_idx_t addr, word_t data);
        i_wb_wen   = 1'b1;
        i_wb_waddr = addr;
        i_wb_wdata = data;
        @(posedge i_clk);
        #1;
        i_wb_wen = 1'b0;
        if (addr != 0) mirror[addr] = data;
    endtask

    task automatic set_fwd(logic ew, reg_idx_t ea, word_t ed, logic mw, reg_idx_t ma, word_t md);
        i_ex_wen    = ew;
        i_ex_waddr  = ea;
        i_ex_wdata  = ed;
        i_mem_wen   = mw;
        i_mem_waddr = ma;
        i_mem_wdata = md;
    endtask

    task automatic issue(inst_t inst, pc_t pc);
        i_inst_vld = 1'b1;
        i_inst     = inst;
        i_pc       = pc;
        @(negedge i_clk);
        while (!o_inst_rdy) @(negedge i_clk);
        exp_q.push_back(expect_issue(inst, pc));
        due_q.push_back(cyc + 1);
        @(posedge i_clk);
        #1;
        i_inst_vld = 1'b0;
        i_ex_wen   = 1'b0;
        i_mem_wen  = 1'b0;
    endtask

    task automatic wait_idle();
        forever begin
            @(posedge i_clk);
            #1;
            if (exp_q.size() == 0 && owed == 0) break;
        end
        @(posedge i_clk);
        #1;
    endtask

    initial begin
        void'($urandom(60697));
        i_arst_n = 1'b0;
        i_inst_vld = 1'b0;
        i_inst = '0;
        i_pc = '0;
        set_fwd(1'b0, '0, '0, 1'b0, '0, '0);
        i_wb_wen = 1'b0;
        i_wb_waddr = '0;
        i_wb_wdata = '0;
        i_credit = 1'b0;
        auto_credit = 1'b1;
        force_credit = 1'b0;
        n_issued = 0;
        owed = 0;
        for (int r = 0; r < 32; r++) mirror[r] = '0;

        cur_test = "reset";
        repeat (8) begin
            @(posedge i_clk);
            #1;
            assert (!o_ex_vld && !o_reg_wen && !o_branch_vld && o_inst_rdy)
                else stop_failed("outputs not in their reset state");
        end
        i_arst_n = 1'b1;  // released after 8 cycles
        repeat (2) begin
            @(posedge i_clk);
            #1;
            assert (!o_ex_vld && !o_reg_wen && !o_branch_vld && o_inst_rdy)
                else stop_failed("outputs left their reset state after release");
        end

        for (int r = 0; r < 32; r++) wb_write(reg_idx_t'(r), $urandom);

        cur_test = "alu_ops";
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k < 6; k++)
                issue(r_type(fns[k], 5'($urandom), 5'($urandom), 5'($urandom)), rnd_pc());
            for (int k = 0; k < 5; k++)
                issue(i_type(opcs[k], 5'($urandom), 5'($urandom), 16'($urandom)), rnd_pc());
        end

        cur_test = "bypass";
        set_fwd(1'b1, 5'd5, $urandom, 1'b1, 5'd5, $urandom);
        issue(r_type(`FN_OR, 5'd5, 5'd6, 5'd7), rnd_pc());
        set_fwd(1'b0, 5'd6, $urandom, 1'b1, 5'd6, $urandom);
        issue(r_type(`FN_ADDU, 5'd5, 5'd6, 5'd8), rnd_pc());
        set_fwd(1'b1, 5'd0, $urandom, 1'b1, 5'd0, $urandom);
        issue(r_type(`FN_XOR, 5'd0, 5'd0, 5'd9), rnd_pc());
        set_fwd(1'b1, 5'd6, $urandom, 1'b1, 5'd5, $urandom);
        issue(r_type(`FN_SUBU, 5'd5, 5'd6, 5'd10), rnd_pc());
        set_fwd(1'b1, 5'd5, $urandom, 1'b0, 5'd0, '0);
        issue(i_type(`OPC_ORI, 5'd5, 5'd11, 16'($urandom)), rnd_pc());

        cur_test = "branch";
        issue(i_type(`OPC_BEQ, 5'd3, 5'd3, 16'hfff0), rnd_pc());
        issue(i_type(`OPC_BEQ, 5'd3, 5'd4, 16'h0020), rnd_pc());
        issue(i_type(`OPC_BNE, 5'd3, 5'd3, 16'h0020), rnd_pc());
        issue(i_type(`OPC_BNE, 5'd3, 5'd4, 16'h8004), rnd_pc());
        set_fwd(1'b1, 5'd4, mirror[3], 1'b0, '0, '0);  // forced equal
        issue(i_type(`OPC_BEQ, 5'd3, 5'd4, 16'h0100), rnd_pc());
        issue({`OPC_J, 26'($urandom)}, rnd_pc());
        issue({`OPC_JAL, 26'($urandom)}, 32'hf000_0ffc);
        issue({`OPC_JAL, 26'($urandom)}, rnd_pc());

        cur_test = "credit";
        wait_idle();
        auto_credit = 1'b0;
        n0 = n_issued;
        fork
            begin
                for (int k = 0; k < 3; k++) issue(r_type(`FN_AND, 5'd1, 5'd2, 5'd3), rnd_pc());
            end
        join_none
        repeat (12) @(posedge i_clk);
        @(negedge i_clk);
        assert (n_issued == n0 + int'(`ID_CREDITS) && !o_inst_rdy)
            else stop_failed("credit count not honored while returns were withheld");
        force_credit = 1'b1;
        repeat (6) @(negedge i_clk);
        assert (n_issued == n0 + int'(`ID_CREDITS) + 1 && !o_inst_rdy)
            else stop_failed("one credit pulse did not give exactly one issue");
        auto_credit = 1'b1;
        wait fork;
        wait_idle();

        cur_test = "unknown";
        issue({6'b111111, 26'($urandom)}, rnd_pc());
        issue(r_type(6'h3f, 5'($urandom), 5'($urandom), 5'($urandom)), rnd_pc());
        wait_idle();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
